// File: common/imu_defs.svh
// ----------------------------------------------------------
// Delays, register tables and packet constants of the
// sensor sequencer. Include wherever one of them is used.
// ----------------------------------------------------------
`ifndef IMU_DEFS_SVH
`define IMU_DEFS_SVH

// Write gaps in clock cycles, scaled down for simulation
`define IMU_RST_DELAY 200
`define IMU_CFG_DELAY 20
`define IMU_DELAY_W   8

// Reset writes, in issue order
`define IMU_N_RST     2
`define IMU_RST_ADDRS '{7'h68, 7'h6B}
`define IMU_RST_VALS  '{8'h03, 8'h80}

// Configuration writes, in issue order
`define IMU_N_CFG     6
`define IMU_CFG_ADDRS '{7'h6B, 7'h6A, 7'h1A, 7'h19, 7'h37, 7'h38}
`define IMU_CFG_VALS  '{8'h05, 8'h10, 8'h08, 8'h07, 8'h10, 8'h01}

// Identity check
`define IMU_WHOAMI_ADDR 7'h75
`define IMU_WHOAMI_VAL  8'h68

// Sample burst from the first accelerometer register
`define IMU_BURST_ADDR 7'h3B
`define IMU_BURST_LEN  14
`define IMU_N_AXES     7
`define IMU_TEMP_AXIS  3

// Stream packet
`define IMU_SAMPLE_TYPE 32'h5350_0001
`define IMU_SAMPLE_SIZE 32'h0000_0020
`define IMU_PKT_WORDS   8

`endif

// File: common/imu_pkg.sv
// ----------------------------------------------------------
// Shared types for the motion sensor acquisition design.
// Modules refer to them by scoped name.
// ----------------------------------------------------------
package imu_pkg;

    // Sensor register address and data byte
    typedef logic [6:0] reg_addr_t;
    typedef logic [7:0] reg_byte_t;

    // Byte count of one register transaction
    typedef logic [5:0] burst_len_t;

    // Free-running cycle timestamp
    typedef logic [63:0] timestamp_t;

    // One axis sample and one packet word
    typedef logic [15:0] sensor_word_t;
    typedef logic [31:0] stream_word_t;

    // Axis index, 0 to 6
    typedef logic [2:0] axis_idx_t;

    // Sequencer phases
    typedef enum logic [3:0] {
        S_DISABLED,
        S_RST_WRITE,
        S_RST_DONE,
        S_RST_WAIT,
        S_CFG_WRITE,
        S_CFG_DONE,
        S_CFG_WAIT,
        S_WHO_READ,
        S_WHO_DONE,
        S_IDLE,
        S_BURST_START,
        S_BURST_RX,
        S_XMIT,
        S_FAULT
    } seq_state_t;

endpackage

// File: common/sample_if.sv
// ----------------------------------------------------------
// Captured sample and frame handshake between the capture,
// framer and sequencer blocks.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

interface sample_if;

    imu_pkg::sensor_word_t axes [`IMU_N_AXES];
    imu_pkg::timestamp_t   stamp;
    logic                  frame_start;
    logic                  frame_done;

    modport capture (output axes, output stamp);
    modport framer  (input axes, input stamp, input frame_start, output frame_done);
    modport control (output frame_start, input frame_done);

endinterface

// File: design/delay_timer.sv
// ----------------------------------------------------------
// Loadable down-counter for the gaps after register writes.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

module delay_timer (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    load,
    input  logic [`IMU_DELAY_W-1:0] delay,
    output logic                    expired
);

    logic [`IMU_DELAY_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            count <= '0;
        else if (load)
            count <= delay;
        else if (count != '0)
            count <= count - 1'b1;
    end

    // Stays high at zero until reloaded
    assign expired = (count == '0);

    // A new gap only starts once the previous one ran out
    a_no_reload: assert property (@(posedge clk) disable iff (!resetn)
        load |-> expired);

endmodule

// File: design/sample_capture.sv
// ----------------------------------------------------------
// Interrupt edge detect, timestamp counter and assembly of
// burst bytes into the seven axis registers.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

module sample_capture (
    input  logic                clk,
    input  logic                resetn,
    input  logic                imu_int,
    input  logic                run,
    input  logic                capture_en,
    input  logic                trx_done,
    input  imu_pkg::reg_byte_t  trx_rdata,
    output logic                int_rise,
    sample_if.capture           cap
);

    logic                int_s1;
    logic                int_s2;
    logic                int_s3;
    imu_pkg::timestamp_t ts_count;
    imu_pkg::burst_len_t byte_idx;
    imu_pkg::axis_idx_t  axis;

    // Two synchronizer flops, third one for the edge
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            int_s1 <= 1'b0;
            int_s2 <= 1'b0;
            int_s3 <= 1'b0;
        end
        else
        begin
            int_s1 <= imu_int;
            int_s2 <= int_s1;
            int_s3 <= int_s2;
        end
    end

    assign int_rise = int_s2 && !int_s3;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            ts_count <= '0;
        else if (run)
            ts_count <= ts_count + 1'b1;
    end

    // Edges during a capture in flight keep the earlier stamp
    always_ff @(posedge clk)
    begin
        if (int_rise && run && !capture_en)
            cap.stamp <= ts_count;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn || !capture_en)
            byte_idx <= '0;
        else if (trx_done)
            byte_idx <= byte_idx + 1'b1;
    end

    assign axis = byte_idx[3:1];

    // High byte arrives first
    always_ff @(posedge clk)
    begin
        if (capture_en && trx_done && !byte_idx[0])
            cap.axes[axis][15:8] <= trx_rdata;
        else if (capture_en && trx_done)
            cap.axes[axis][7:0] <= trx_rdata;
    end

endmodule

// File: design/packet_framer.sv
// ----------------------------------------------------------
// Sends one captured sample as an eight-word stream packet,
// holding each word while the sink stalls.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

module packet_framer #(
    parameter int unsigned DEVICE_ID = 0
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  tready,
    output logic                  tvalid,
    output imu_pkg::stream_word_t tdata,
    output logic                  tlast,
    sample_if.framer              frm
);

    localparam int IDX_W = $clog2(`IMU_PKT_WORDS);

    logic [IDX_W-1:0] word_idx;
    logic             accept;

    assign accept = tvalid && tready;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            tvalid   <= 1'b0;
            word_idx <= '0;
        end
        else if (frm.frame_start)
        begin
            tvalid   <= 1'b1;
            word_idx <= '0;
        end
        else if (accept && tlast)
            tvalid <= 1'b0;
        else if (accept)
            word_idx <= word_idx + 1'b1;
    end

    assign tlast          = tvalid && (word_idx == IDX_W'(`IMU_PKT_WORDS - 1));
    assign frm.frame_done = accept && tlast;

    // Word select; sources hold still until the packet is out
    always_comb
    begin
        case (word_idx)
            3'd0:    tdata = `IMU_SAMPLE_TYPE;
            3'd1:    tdata = `IMU_SAMPLE_SIZE;
            3'd2:    tdata = frm.stamp[31:0];
            3'd3:    tdata = frm.stamp[63:32];
            3'd4:    tdata = {15'b0, frm.axes[`IMU_TEMP_AXIS][0], 16'(DEVICE_ID)};
            3'd5:    tdata = {frm.axes[1], frm.axes[0]};
            3'd6:    tdata = {frm.axes[4], frm.axes[2]};
            default: tdata = {frm.axes[6], frm.axes[5]};
        endcase
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (!resetn)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast));

endmodule

// File: design/sequencer/imu_sequencer.sv
// ----------------------------------------------------------
// Sensor bring-up and sampling FSM. Walks reset and config
// writes, checks WHOAMI, then runs a burst read per interrupt.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

module imu_sequencer (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    enable,
    input  logic                    run,
    input  logic                    int_rise,
    output logic                    trx_start,
    output logic                    trx_read,
    output imu_pkg::reg_addr_t      trx_addr,
    output imu_pkg::reg_byte_t      trx_wdata,
    output imu_pkg::burst_len_t     trx_len,
    input  logic                    trx_done,
    input  imu_pkg::reg_byte_t      trx_rdata,
    output logic                    timer_load,
    output logic [`IMU_DELAY_W-1:0] timer_delay,
    input  logic                    timer_expired,
    output logic                    capture_en,
    output logic                    fault,
    sample_if.control               ctrl
);

    localparam imu_pkg::reg_addr_t RST_ADDRS [`IMU_N_RST] = `IMU_RST_ADDRS;
    localparam imu_pkg::reg_byte_t RST_VALS  [`IMU_N_RST] = `IMU_RST_VALS;
    localparam imu_pkg::reg_addr_t CFG_ADDRS [`IMU_N_CFG] = `IMU_CFG_ADDRS;
    localparam imu_pkg::reg_byte_t CFG_VALS  [`IMU_N_CFG] = `IMU_CFG_VALS;

    imu_pkg::seq_state_t               state;
    logic [$clog2(`IMU_N_RST)-1:0]     rst_idx;
    logic [$clog2(`IMU_N_CFG)-1:0]     cfg_idx;
    imu_pkg::burst_len_t               byte_cnt;

    // One start pulse per issue state
    assign trx_start = (state == imu_pkg::S_RST_WRITE) || (state == imu_pkg::S_CFG_WRITE) ||
                       (state == imu_pkg::S_WHO_READ)  || (state == imu_pkg::S_BURST_START);

    // Transaction fields stay put for the whole phase
    always_comb
    begin
        trx_read  = 1'b0;
        trx_addr  = '0;
        trx_wdata = '0;
        trx_len   = 6'd1;
        case (state)
            imu_pkg::S_RST_WRITE, imu_pkg::S_RST_DONE:
            begin
                trx_addr  = RST_ADDRS[rst_idx];
                trx_wdata = RST_VALS[rst_idx];
            end
            imu_pkg::S_CFG_WRITE, imu_pkg::S_CFG_DONE:
            begin
                trx_addr  = CFG_ADDRS[cfg_idx];
                trx_wdata = CFG_VALS[cfg_idx];
            end
            imu_pkg::S_WHO_READ, imu_pkg::S_WHO_DONE:
            begin
                trx_read = 1'b1;
                trx_addr = `IMU_WHOAMI_ADDR;
            end
            imu_pkg::S_BURST_START, imu_pkg::S_BURST_RX:
            begin
                trx_read = 1'b1;
                trx_addr = `IMU_BURST_ADDR;
                trx_len  = 6'(`IMU_BURST_LEN);
            end
            default:
            begin
                trx_read = 1'b0;
            end
        endcase
    end

    // Gap timer starts on a write's done
    assign timer_load  = trx_done &&
                         (state == imu_pkg::S_RST_DONE || state == imu_pkg::S_CFG_DONE);
    assign timer_delay = (state == imu_pkg::S_RST_DONE) ? `IMU_DELAY_W'(`IMU_RST_DELAY)
                                                         : `IMU_DELAY_W'(`IMU_CFG_DELAY);

    // Held from burst issue until the packet leaves
    assign capture_en = (state == imu_pkg::S_BURST_START) || (state == imu_pkg::S_BURST_RX) ||
                        (state == imu_pkg::S_XMIT);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state            <= imu_pkg::S_DISABLED;
            rst_idx          <= '0;
            cfg_idx          <= '0;
            byte_cnt         <= '0;
            fault            <= 1'b0;
            ctrl.frame_start <= 1'b0;
        end
        else
        begin
            ctrl.frame_start <= 1'b0;
            case (state)
                imu_pkg::S_DISABLED:
                begin
                    rst_idx <= '0;
                    cfg_idx <= '0;
                    if (enable)
                        state <= imu_pkg::S_RST_WRITE;
                end
                imu_pkg::S_RST_WRITE: state <= imu_pkg::S_RST_DONE;
                imu_pkg::S_RST_DONE:
                begin
                    if (trx_done)
                        state <= imu_pkg::S_RST_WAIT;
                end
                imu_pkg::S_RST_WAIT:
                begin
                    if (timer_expired && rst_idx == `IMU_N_RST - 1)
                        state <= imu_pkg::S_CFG_WRITE;
                    else if (timer_expired)
                    begin
                        rst_idx <= rst_idx + 1'b1;
                        state   <= imu_pkg::S_RST_WRITE;
                    end
                end
                imu_pkg::S_CFG_WRITE: state <= imu_pkg::S_CFG_DONE;
                imu_pkg::S_CFG_DONE:
                begin
                    if (trx_done)
                        state <= imu_pkg::S_CFG_WAIT;
                end
                imu_pkg::S_CFG_WAIT:
                begin
                    if (timer_expired && cfg_idx == `IMU_N_CFG - 1)
                        state <= imu_pkg::S_WHO_READ;
                    else if (timer_expired)
                    begin
                        cfg_idx <= cfg_idx + 1'b1;
                        state   <= imu_pkg::S_CFG_WRITE;
                    end
                end
                imu_pkg::S_WHO_READ: state <= imu_pkg::S_WHO_DONE;
                imu_pkg::S_WHO_DONE:
                begin
                    if (trx_done && trx_rdata != `IMU_WHOAMI_VAL)
                    begin
                        fault <= 1'b1;
                        state <= imu_pkg::S_FAULT;
                    end
                    else if (trx_done)
                        state <= imu_pkg::S_IDLE;
                end
                imu_pkg::S_IDLE:
                begin
                    if (!enable)
                        state <= imu_pkg::S_DISABLED;
                    else if (run && int_rise)
                        state <= imu_pkg::S_BURST_START;
                end
                imu_pkg::S_BURST_START:
                begin
                    byte_cnt <= '0;
                    state    <= imu_pkg::S_BURST_RX;
                end
                imu_pkg::S_BURST_RX:
                begin
                    if (trx_done && byte_cnt == `IMU_BURST_LEN - 1)
                    begin
                        ctrl.frame_start <= 1'b1;
                        state            <= imu_pkg::S_XMIT;
                    end
                    else if (trx_done)
                        byte_cnt <= byte_cnt + 1'b1;
                end
                imu_pkg::S_XMIT:
                begin
                    if (ctrl.frame_done)
                        state <= imu_pkg::S_IDLE;
                end
                imu_pkg::S_FAULT:
                begin
                    // Latched until the host drops enable
                    if (!enable)
                    begin
                        fault <= 1'b0;
                        state <= imu_pkg::S_DISABLED;
                    end
                end
                default: state <= imu_pkg::S_DISABLED;
            endcase
        end
    end

    a_start_single: assert property (@(posedge clk) disable iff (!resetn)
        trx_start |=> !trx_start);

    a_fault_quiet: assert property (@(posedge clk) disable iff (!resetn)
        fault |-> !trx_start);

endmodule

// File: design/imu_acquire.sv
// ----------------------------------------------------------
// Top level of the sensor acquisition sequencer. Connects
// to a register-transaction port and a valid/ready stream.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

module imu_acquire #(
    parameter int unsigned DEVICE_ID = 0
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     enable,
    input  logic                     run,
    input  logic                     imu_int,
    output logic                     trx_start,
    output logic                     trx_read,
    output imu_pkg::reg_addr_t       trx_addr,
    output imu_pkg::reg_byte_t       trx_wdata,
    output imu_pkg::burst_len_t      trx_len,
    input  logic                     trx_done,
    input  imu_pkg::reg_byte_t       trx_rdata,
    output logic                     tvalid,
    input  logic                     tready,
    output imu_pkg::stream_word_t    tdata,
    output logic                     tlast,
    output logic                     fault
);

    logic                    int_rise;
    logic                    capture_en;
    logic                    timer_load;
    logic [`IMU_DELAY_W-1:0] timer_delay;
    logic                    timer_expired;

    sample_if smp ();

    imu_sequencer sequencer_inst (
        .clk           (clk),
        .resetn        (resetn),
        .enable        (enable),
        .run           (run),
        .int_rise      (int_rise),
        .trx_start     (trx_start),
        .trx_read      (trx_read),
        .trx_addr      (trx_addr),
        .trx_wdata     (trx_wdata),
        .trx_len       (trx_len),
        .trx_done      (trx_done),
        .trx_rdata     (trx_rdata),
        .timer_load    (timer_load),
        .timer_delay   (timer_delay),
        .timer_expired (timer_expired),
        .capture_en    (capture_en),
        .fault         (fault),
        .ctrl          (smp.control)
    );

    delay_timer timer_inst (
        .clk     (clk),
        .resetn  (resetn),
        .load    (timer_load),
        .delay   (timer_delay),
        .expired (timer_expired)
    );

    sample_capture capture_inst (
        .clk        (clk),
        .resetn     (resetn),
        .imu_int    (imu_int),
        .run        (run),
        .capture_en (capture_en),
        .trx_done   (trx_done),
        .trx_rdata  (trx_rdata),
        .int_rise   (int_rise),
        .cap        (smp.capture)
    );

    packet_framer #(
        .DEVICE_ID (DEVICE_ID)
    ) framer_inst (
        .clk    (clk),
        .resetn (resetn),
        .tready (tready),
        .tvalid (tvalid),
        .tdata  (tdata),
        .tlast  (tlast),
        .frm    (smp.framer)
    );

endmodule

// File: tb/imu_bus_model.sv
// ----------------------------------------------------------
// Sensor register model behind the transaction port. Logs
// each transaction and answers done pulses after a latency.
// ----------------------------------------------------------
`timescale 1ns/10ps

module imu_bus_model (
    input  logic                clk,
    input  logic                resetn,
    input  logic                trx_start,
    input  logic                trx_read,
    input  imu_pkg::reg_addr_t  trx_addr,
    input  imu_pkg::reg_byte_t  trx_wdata,
    input  imu_pkg::burst_len_t trx_len,
    input  logic [1:0]          lat,
    output logic                trx_done,
    output imu_pkg::reg_byte_t  trx_rdata
);

    // Register file, filled by the testbench top
    imu_pkg::reg_byte_t regs [128];

    // One entry per transaction: {read, len, addr, wdata}
    logic [21:0] log_q [$];

    logic [1:0] lat_q;

    always @(posedge clk)
        lat_q <= lat;

    initial
    begin
        int                 k;
        int                 nbytes;
        logic               is_read;
        imu_pkg::reg_addr_t addr;
        trx_done  = 1'b0;
        trx_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (resetn && trx_start)
            begin
                is_read = trx_read;
                addr    = trx_addr;
                nbytes  = trx_read ? int'(trx_len) : 1;
                log_q.push_back({trx_read, trx_len, trx_addr, trx_wdata});
                // Reads return bytes in address order
                for (int i = 0; i < nbytes; i++)
                begin
                    k = int'(lat_q) + 1;
                    repeat (k)
                    begin
                        @(posedge clk);
                        #10;
                        trx_done = 1'b0;
                    end
                    trx_done  = 1'b1;
                    trx_rdata = is_read ? regs[7'(int'(addr) + i)] : 8'h00;
                end
                @(posedge clk);
                #10;
                trx_done = 1'b0;
            end
        end
    end

endmodule

// File: tb/tb_imu_acquire.sv
// ----------------------------------------------------------
// Testbench for the acquisition sequencer. Runs bring-up,
// fault, packet, back-pressure and gating scenarios.
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "imu_defs.svh"

module tb_imu_acquire;

    localparam int          CLK_PERIOD = 100;
    localparam int unsigned DEVICE_ID  = 16'h2A5C;
    localparam int          N_PKT      = 5;
    localparam int          INIT_CYCLES = `IMU_N_RST * `IMU_RST_DELAY +
                                          `IMU_N_CFG * `IMU_CFG_DELAY;
    // Two bring-ups, packets, plus the fault and gating windows
    localparam int WATCHDOG_CYCLES = 2 * (2 * INIT_CYCLES) + 200 * (N_PKT + 2);

    localparam logic [6:0] RST_ADDRS [`IMU_N_RST] = `IMU_RST_ADDRS;
    localparam logic [7:0] RST_VALS  [`IMU_N_RST] = `IMU_RST_VALS;
    localparam logic [6:0] CFG_ADDRS [`IMU_N_CFG] = `IMU_CFG_ADDRS;
    localparam logic [7:0] CFG_VALS  [`IMU_N_CFG] = `IMU_CFG_VALS;

    logic clk;
    logic resetn;
    logic enable;
    logic run;
    logic imu_int;
    logic trx_start;
    logic trx_read;
    logic [6:0] trx_addr;
    logic [7:0] trx_wdata;
    logic [5:0] trx_len;
    logic trx_done;
    logic [7:0] trx_rdata;
    logic tvalid;
    logic tready;
    logic [31:0] tdata;
    logic tlast;
    logic fault;
    logic [1:0] lat;
    logic stall_mode;
    logic [31:0] lfsr_state;
    logic [63:0] last_stamp;
    logic [63:0] run_cycles;
    logic [63:0] pin_count;
    logic [31:0] word_q [$];
    logic last_q [$];
    int errors;
    int checks;
    int cycle;
    int last_done;
    int gap_need;
    int wr_count;
    logic gap_pending;

    imu_acquire #(.DEVICE_ID(DEVICE_ID)) imu_acquire_inst (
        .clk(clk), .resetn(resetn), .enable(enable), .run(run), .imu_int(imu_int),
        .trx_start(trx_start), .trx_read(trx_read), .trx_addr(trx_addr),
        .trx_wdata(trx_wdata), .trx_len(trx_len), .trx_done(trx_done),
        .trx_rdata(trx_rdata), .tvalid(tvalid), .tready(tready), .tdata(tdata),
        .tlast(tlast), .fault(fault)
    );

    imu_bus_model bus_model_inst (
        .clk(clk), .resetn(resetn), .trx_start(trx_start), .trx_read(trx_read),
        .trx_addr(trx_addr), .trx_wdata(trx_wdata), .trx_len(trx_len), .lat(lat),
        .trx_done(trx_done), .trx_rdata(trx_rdata)
    );

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp === act) else report_mismatch(name, exp, act);
    endtask

    task automatic expect_in_range(input string name, input logic [63:0] lo,
                                   input logic [63:0] hi, input logic [63:0] act);
        checks++;
        assert (act >= lo && act <= hi)
        else
        begin
            errors++;
            $display("[FAIL] %s expected %0h to %0h actual %0h", name, lo, hi, act);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Latency and back-pressure bits each cycle
    always @(posedge clk)
    begin
        #10;
        lat    = 2'(take_bits(2));
        tready = stall_mode ? (take_bits(1) != 0) : 1'b1;
    end

    // Monitors sample in mid-cycle where outputs are settled
    always @(negedge clk)
    begin
        cycle++;
        // Cycles with run high out of reset
        if (resetn && run)
            run_cycles++;
        if (tvalid && tready)
        begin
            word_q.push_back(tdata);
            last_q.push_back(tlast);
        end
        if (!enable)
        begin
            wr_count    = 0;
            gap_pending = 1'b0;
        end
        if (trx_start && gap_pending)
        begin
            checks++;
            assert (cycle - last_done >= gap_need)
            else report_mismatch("write_gap", 64'(gap_need), 64'(cycle - last_done));
        end
        if (trx_start)
            gap_pending = 1'b0;
        if (trx_done && !trx_read)
        begin
            last_done   = cycle;
            gap_need    = (wr_count < `IMU_N_RST) ? `IMU_RST_DELAY : `IMU_CFG_DELAY;
            wr_count++;
            gap_pending = 1'b1;
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!resetn)
        tvalid && !tready |=> $stable(tdata) && $stable(tlast))
        else
        begin
            errors++;
            $display("[FAIL] stall_hold: stream word changed while stalled");
        end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic pulse_int();
        @(posedge clk);
        #10;
        imu_int   = 1'b1;
        pin_count = run_cycles;
        repeat (4) @(posedge clk);
        #10;
        imu_int = 1'b0;
    endtask

    // Bring-up writes and the identity read in table order
    task automatic verify_bringup(input string tag);
        logic [21:0] e;
        while (bus_model_inst.log_q.size() < `IMU_N_RST + `IMU_N_CFG + 1)
            @(posedge clk);
        repeat (12) @(posedge clk);
        check_eq({tag, " trx count"}, `IMU_N_RST + `IMU_N_CFG + 1,
                 bus_model_inst.log_q.size());
        for (int i = 0; i < `IMU_N_RST; i++)
        begin
            e = bus_model_inst.log_q[i];
            check_eq({tag, " rst read"}, 0, e[21]);
            check_eq({tag, " rst addr"}, RST_ADDRS[i], e[14:8]);
            check_eq({tag, " rst data"}, RST_VALS[i], e[7:0]);
        end
        for (int i = 0; i < `IMU_N_CFG; i++)
        begin
            e = bus_model_inst.log_q[`IMU_N_RST + i];
            check_eq({tag, " cfg read"}, 0, e[21]);
            check_eq({tag, " cfg addr"}, CFG_ADDRS[i], e[14:8]);
            check_eq({tag, " cfg data"}, CFG_VALS[i], e[7:0]);
        end
        e = bus_model_inst.log_q[`IMU_N_RST + `IMU_N_CFG];
        check_eq({tag, " whoami read"}, 1, e[21]);
        check_eq({tag, " whoami addr"}, `IMU_WHOAMI_ADDR, e[14:8]);
        check_eq({tag, " whoami len"}, 1, e[20:15]);
    endtask

    task automatic send_packet();
        logic [15:0] ax [`IMU_N_AXES];
        logic [31:0] exp [`IMU_PKT_WORDS];
        logic [31:0] got [`IMU_PKT_WORDS];
        logic [63:0] stamp;
        logic [21:0] e;
        bus_model_inst.log_q.delete();
        pulse_int();
        while (word_q.size() < `IMU_PKT_WORDS)
            @(posedge clk);
        repeat (20) @(posedge clk);
        check_eq("burst count", 1, bus_model_inst.log_q.size());
        e = bus_model_inst.log_q[0];
        check_eq("burst read", 1, e[21]);
        check_eq("burst addr", `IMU_BURST_ADDR, e[14:8]);
        check_eq("burst len", `IMU_BURST_LEN, e[20:15]);
        check_eq("word count", `IMU_PKT_WORDS, word_q.size());
        // Axes from the model's registers with the high byte first
        for (int i = 0; i < `IMU_N_AXES; i++)
            ax[i] = {bus_model_inst.regs[`IMU_BURST_ADDR + 2 * i],
                     bus_model_inst.regs[`IMU_BURST_ADDR + 2 * i + 1]};
        for (int i = 0; i < `IMU_PKT_WORDS; i++)
        begin
            got[i] = word_q.pop_front();
            check_eq($sformatf("tlast word %0d", i), (i == `IMU_PKT_WORDS - 1),
                     last_q.pop_front());
        end
        // Stamp is latched within three cycles of the pin rising
        stamp = {got[3], got[2]};
        expect_in_range("packet stamp", pin_count, pin_count + 3, stamp);
        exp[0] = `IMU_SAMPLE_TYPE;
        exp[1] = `IMU_SAMPLE_SIZE;
        exp[4] = {15'b0, ax[`IMU_TEMP_AXIS][0], DEVICE_ID[15:0]};
        exp[5] = {ax[1], ax[0]};
        exp[6] = {ax[4], ax[2]};
        exp[7] = {ax[6], ax[5]};
        for (int i = 0; i < `IMU_PKT_WORDS; i++)
            if (i != 2 && i != 3)
                check_eq($sformatf("packet word %0d", i), exp[i], got[i]);
        check_eq("stamp increases", 1, stamp > last_stamp);
        last_stamp = stamp;
        word_q.delete();
        last_q.delete();
    endtask

    initial
    begin
        resetn      = 1'b0;
        enable      = 1'b0;
        run         = 1'b0;
        imu_int     = 1'b0;
        tready      = 1'b1;
        lat         = 2'd0;
        stall_mode  = 1'b0;
        lfsr_state  = 32'h4f295724;
        last_stamp  = '0;
        run_cycles  = '0;
        pin_count   = '0;
        errors      = 0;
        checks      = 0;
        cycle       = 0;
        last_done   = 0;
        gap_need    = 0;
        wr_count    = 0;
        gap_pending = 1'b0;
        for (int a = 0; a < 128; a++)
            bus_model_inst.regs[a] = 8'(take_bits(8));
        bus_model_inst.regs[`IMU_WHOAMI_ADDR] = ~`IMU_WHOAMI_VAL;
        repeat (16) @(posedge clk);
        #10;
        resetn = 1'b1;

        // Wrong identity latches fault and blocks sampling
        @(posedge clk);
        #10;
        enable = 1'b1;
        run    = 1'b1;
        verify_bringup("fault init");
        check_eq("fault set", 1, fault);
        pulse_int();
        repeat (40) @(posedge clk);
        check_eq("fault no burst", 9, bus_model_inst.log_q.size());
        check_eq("fault no stream", 0, word_q.size());
        @(posedge clk);
        #10;
        enable = 1'b0;
        repeat (3) @(posedge clk);
        check_eq("fault clear", 0, fault);

        // Correct identity brings the sequencer to idle
        bus_model_inst.regs[`IMU_WHOAMI_ADDR] = `IMU_WHOAMI_VAL;
        bus_model_inst.log_q.delete();
        @(posedge clk);
        #10;
        enable = 1'b1;
        verify_bringup("good init");
        check_eq("fault stays low", 0, fault);

        for (int p = 0; p < 2; p++)
            send_packet();
        stall_mode = 1'b1;
        for (int p = 0; p < N_PKT - 2; p++)
            send_packet();

        // Interrupts with run low are ignored
        bus_model_inst.log_q.delete();
        @(posedge clk);
        #10;
        run = 1'b0;
        pulse_int();
        repeat (40) @(posedge clk);
        check_eq("gated burst", 0, bus_model_inst.log_q.size());
        check_eq("gated stream", 0, word_q.size());

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: imu_acquire.f
+incdir+common
common/imu_pkg.sv
common/sample_if.sv
design/delay_timer.sv
design/sample_capture.sv
design/packet_framer.sv
design/sequencer/imu_sequencer.sv
design/imu_acquire.sv
tb/imu_bus_model.sv
tb/tb_imu_acquire.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_imu_acquire
RTL_TOP    ?= imu_acquire
FILELIST   ?= imu_acquire.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
